// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module tb_spi_master -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_spi_master)"; echo "$$out"; \
		echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

// File: bench/spi_checker.sv
`timescale 1ns/1ps

module spi_checker (
    input logic       HCLK,
    input logic       slave_cs,
    input logic       sclk,
    input logic [7:0] ss,
    input logic       watch,                     // Bus checks on
    input logic       exp_cpol,                  // Idle sclk level
    input logic [2:0] exp_sel,                   // Slave that should be selected
    input logic [7:0] exp_half                   // sclk half period in HCLK cycles
);

    int   errors = 0;
    int   passed = 0;
    int   failed = 0;
    int   mark = 0;                              // Error count when the test began
    int   run_len = 0;                           // Samples since the last sclk edge
    logic last_sclk = 1'b0;

    task automatic compare(input string name, input logic [7:0] exp_val,
                           input logic [7:0] act_val);
        if (act_val !== exp_val) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic finish_test(input string name);
        if (errors == mark) begin
            passed++;
            $display("Test %s: passed", name);
        end else begin
            failed++;
            $display("Test %s: failed with %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    task automatic summary();
        $display("Summary: %0d tests passed, %0d failed, %0d errors", passed, failed, errors);
    endtask

    // Rising edge sees the values settled during the last cycle
    always @(posedge HCLK) begin
        if (slave_cs || !watch) begin
            run_len = 0;
        end else if (ss == 8'hFF) begin
            run_len = 0;                         // No transfer, sclk parked
            compare("sclk idle level", {7'd0, exp_cpol}, {7'd0, sclk});
        end else begin
            compare("ss", ~(8'd1 << exp_sel), ss);
            if (sclk == last_sclk) begin
                run_len++;
            end else begin
                compare("sclk half period", exp_half, 8'(run_len));
                run_len = 1;                     // Edge sample opens the next half period
            end
        end
        last_sclk = sclk;
    end

endmodule

// File: bench/spi_clock_source.sv
`timescale 1ns/1ps

module spi_clock_source #(
    parameter int HALF_PERIOD = 50               // 100 ns period
) (
    output logic HCLK
);

    initial begin
        HCLK = 1'b0;
    end

    always #(HALF_PERIOD) HCLK = ~HCLK;

endmodule

// File: bench/tb_spi_master.sv
`timescale 1ns/1ps

module tb_spi_master;

    typedef struct packed {
        logic [7:0] ctrl;                        // Control register value
        logic [7:0] tx;                          // Master transmit byte
        logic [7:0] reply;                       // Slave reply byte
        logic       rnd;                         // Reply from xorshift instead
        logic       ovr;                         // Extra transmit write mid transfer
    } test_row_t;

    localparam int NUM_TESTS = 6;

    // Columns are control, transmit, reply, random reply, overrun write
    localparam test_row_t TESTS [NUM_TESTS] = '{
        '{8'h00, 8'hA5, 8'h3C, 1'b0, 1'b0},      // Mode 0, div 0, ss 0
        '{8'h71, 8'h5A, 8'hC3, 1'b0, 1'b0},      // Mode 1, div 1, ss 3
        '{8'hAA, 8'hF0, 8'h0F, 1'b0, 1'b0},      // Mode 2, div 2, ss 5
        '{8'hFB, 8'h81, 8'h7E, 1'b0, 1'b1},      // Mode 3, div 3, ss 7
        '{8'h58, 8'h00, 8'h00, 1'b1, 1'b0},      // Mode 3, div 0, ss 2
        '{8'h12, 8'hFF, 8'h00, 1'b1, 1'b1}       // Mode 1, div 2, ss 0
    };

    logic               HCLK;
    logic               slave_cs = 1'b1;
    logic               cs = 1'b0;
    logic               wr = 1'b0;
    logic               rd = 1'b0;
    spi_pkg::reg_addr_t addr = '0;
    logic [7:0]         wdata = 8'h00;
    logic [7:0]         rdata;
    logic               miso = 1'b0;
    logic               mosi;
    logic               sclk;
    logic [7:0]         ss;
    logic               watch = 1'b0;            // Checker bus checks on
    logic               cur_cpol = 1'b0;
    logic               cur_cpha = 1'b0;
    logic [2:0]         cur_sel = 3'd0;
    logic [7:0]         cur_half = 8'd1;
    logic [7:0]         slave_reply = 8'h00;     // Loaded when ss falls
    logic [7:0]         slave_rec = 8'h00;       // mosi bits seen by the slave
    logic [7:0]         slave_sh = 8'h00;
    logic               slave_on = 1'b0;
    logic               sclk_q = 1'b0;           // Bus as seen one HCLK earlier
    logic               mosi_q = 1'b0;

    spi_clock_source u_clock_source (.HCLK(HCLK));

    spi_master_top #(.NUM_SS(8)) u_spi_master_top (
        .HCLK(HCLK), .slave_cs(slave_cs), .cs(cs), .wr(wr), .rd(rd), .addr(addr),
        .wdata(wdata), .rdata(rdata), .miso(miso), .mosi(mosi), .sclk(sclk), .ss(ss)
    );

    spi_checker u_checker (
        .HCLK(HCLK), .slave_cs(slave_cs), .sclk(sclk), .ss(ss), .watch(watch),
        .exp_cpol(cur_cpol), .exp_sel(cur_sel), .exp_half(cur_half)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic write_reg(input spi_pkg::reg_addr_t a, input logic [7:0] d);
        @(negedge HCLK);
        cs    = 1'b1;
        wr    = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge HCLK);
        cs = 1'b0;
        wr = 1'b0;
    endtask

    task automatic read_reg(input spi_pkg::reg_addr_t a, output logic [7:0] d);
        @(negedge HCLK);
        cs   = 1'b1;
        rd   = 1'b1;
        addr = a;
        @(negedge HCLK);
        cs = 1'b0;
        rd = 1'b0;
        d  = rdata;                              // Registered on the rising edge between
    endtask

    // Polls status until a bit in mask is set
    task automatic wait_status(input logic [7:0] mask, input int limit, input string what,
                               output logic [7:0] st);
        int n;
        n  = 0;
        st = 8'h00;
        while (((st & mask) == 8'h00) && (n < limit)) begin
            read_reg(spi_pkg::ADDR_STATUS, st);
            n++;
        end
        if ((st & mask) == 8'h00) begin
            u_checker.report_problem({"timed out waiting for ", what});
        end
    endtask

    task automatic run_transfer(input test_row_t row, input logic [7:0] reply);
        logic [7:0] st;
        logic [7:0] rx;
        watch = 1'b0;                            // sclk follows a new CPOL a cycle late
        write_reg(spi_pkg::ADDR_CONTROL, row.ctrl);
        @(negedge HCLK);
        cur_cpol    = row.ctrl[3];
        cur_cpha    = row.ctrl[4];
        cur_sel     = row.ctrl[7:5];
        cur_half    = 8'(1 << row.ctrl[2:0]);
        slave_reply = reply;
        watch       = 1'b1;
        write_reg(spi_pkg::ADDR_TXDATA, row.tx);
        wait_status(8'h04, 10, "busy", st);
        u_checker.compare("status while busy", 8'h04, st);
        if (row.ovr) begin
            write_reg(spi_pkg::ADDR_TXDATA, ~row.tx);    // Dropped, sets overrun
            read_reg(spi_pkg::ADDR_STATUS, st);
            u_checker.compare("status after overrun", 8'h06, st);
        end
        wait_status(8'h01, (40 << row.ctrl[2:0]) + 20, "done", st);
        u_checker.compare("status at done", row.ovr ? 8'h03 : 8'h01, st);
        read_reg(spi_pkg::ADDR_RXDATA, rx);
        u_checker.compare("rxdata", reply, rx);
        u_checker.compare("slave mosi byte", row.tx, slave_rec);
        read_reg(spi_pkg::ADDR_STATUS, st);
        u_checker.compare("status after rx read", row.ovr ? 8'h02 : 8'h00, st);
    endtask

    // Serial slave, watches the bus on the falling edge
    always @(negedge HCLK) begin
        logic is_lead;
        is_lead = (sclk != cur_cpol);            // Leaving idle level
        if (slave_on && (sclk != sclk_q)) begin
            if (is_lead ^ cur_cpha) begin
                slave_rec = {slave_rec[6:0], mosi_q};   // Sampling edge
            end else begin
                miso     = slave_sh[7];          // Shifting edge
                slave_sh = {slave_sh[6:0], 1'b0};
            end
        end
        if (!slave_on && (ss != 8'hFF)) begin
            slave_on = 1'b1;
            slave_sh = slave_reply;
            if (!cur_cpha) begin
                miso     = slave_sh[7];          // Bit 7 ahead of the first lead edge
                slave_sh = {slave_sh[6:0], 1'b0};
            end
        end else if (ss == 8'hFF) begin
            slave_on = 1'b0;
        end
        sclk_q = sclk;
        mosi_q = mosi;
    end

    initial begin
        logic [7:0]  st;
        logic [7:0]  reply;
        logic [31:0] rng;
        rng = 32'd84598;
        repeat (4) @(negedge HCLK);
        slave_cs = 1'b0;
        u_checker.compare("sclk", 8'h00, {7'd0, sclk});
        u_checker.compare("ss", 8'hFF, ss);
        read_reg(spi_pkg::ADDR_STATUS, st);
        u_checker.compare("status", 8'h00, st);
        u_checker.finish_test("reset");
        for (int i = 0; i < NUM_TESTS; i++) begin
            reply = TESTS[i].reply;
            if (TESTS[i].rnd) begin
                rng   = xorshift(rng);
                reply = rng[7:0];
            end
            run_transfer(TESTS[i], reply);
            u_checker.finish_test($sformatf("transfer %0d control %h", i, TESTS[i].ctrl));
        end
        u_checker.summary();
        if (u_checker.errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: common/spi_pkg.sv
package spi_pkg;

    typedef logic [7:0] spi_byte_t;      // One byte on the host bus or the wire
    typedef logic [1:0] reg_addr_t;      // Register select
    typedef logic [2:0] div_sel_t;       // Half period is 2**div_sel HCLK cycles
    typedef logic [2:0] ss_code_t;       // Binary slave select code

    localparam reg_addr_t ADDR_CONTROL = 2'd0;   // Mode, divider and slave code
    localparam reg_addr_t ADDR_STATUS  = 2'd1;   // Busy, overrun and done flags
    localparam reg_addr_t ADDR_TXDATA  = 2'd2;   // Write starts a transfer
    localparam reg_addr_t ADDR_RXDATA  = 2'd3;   // Read clears done

    // Control register in bit order, msb first
    typedef struct packed {
        ss_code_t ss_code;               // Bits 7:5
        logic     cpha;                  // Bit 4
        logic     cpol;                  // Bit 3
        div_sel_t div_sel;               // Bits 2:0
    } spi_control_t;

    typedef struct packed {
        logic [4:0] reserved;            // Read as zero
        logic       busy;                // Bit 2
        logic       overrun;             // Bit 1
        logic       done;                // Bit 0
    } spi_status_t;

    // One host access as seen on a single HCLK cycle
    typedef struct packed {
        logic      cs;                   // Chip select
        logic      wr;                   // Write strobe
        logic      rd;                   // Read strobe
        reg_addr_t addr;                 // Register address
        spi_byte_t wdata;                // Write data
    } host_req_t;

    typedef struct packed {
        logic busy;                      // Transfer in progress
        logic word_done;                 // Pulse after the last sclk edge
        logic start_rejected;            // Pulse on a dropped transmit write
    } engine_stat_t;

endpackage

// File: source/spi_master_top.sv
`timescale 1ns/1ps

module spi_master_top #(
    parameter int NUM_SS = 8                     // Slave select lines, 1 to 8
) (
    input  logic               HCLK,
    input  logic               slave_cs,
    input  logic               cs,
    input  logic               wr,
    input  logic               rd,
    input  spi_pkg::reg_addr_t addr,
    input  spi_pkg::spi_byte_t wdata,
    output spi_pkg::spi_byte_t rdata,
    input  logic               miso,
    output logic               mosi,
    output logic               sclk,
    output logic [NUM_SS-1:0]  ss
);

    spi_pkg::host_req_t    req;
    spi_pkg::spi_control_t control;
    spi_pkg::spi_status_t  status;
    spi_pkg::engine_stat_t eng_stat;             // From the shift engine
    spi_pkg::engine_stat_t rx_stat;              // Engine status with decoder reject
    spi_pkg::spi_byte_t    txdata;
    spi_pkg::spi_byte_t    rxdata;
    spi_pkg::spi_byte_t    rx_byte;
    logic                  start;
    logic                  start_rejected;
    logic                  rd_rx;
    logic                  run;
    logic                  lead_edge;
    logic                  trail_edge;

    if (NUM_SS < 1 || NUM_SS > 8) begin : g_num_ss_check
        $error("NUM_SS must be between 1 and 8");
    end

    assign req = '{cs: cs, wr: wr, rd: rd, addr: addr, wdata: wdata};

    always_comb begin
        rx_stat                = eng_stat;
        rx_stat.start_rejected = start_rejected; // Overrun is found in the decoder
    end

    // Active low select, codes at or above NUM_SS hit no line
    always_comb begin
        for (int i = 0; i < NUM_SS; i++) begin
            ss[i] = ~(eng_stat.busy && (control.ss_code == spi_pkg::ss_code_t'(i)));
        end
    end

    spi_reg_decode u_spi_reg_decode (
        .HCLK           (HCLK),
        .slave_cs       (slave_cs),
        .req            (req),
        .busy           (eng_stat.busy),
        .status         (status),
        .rxdata         (rxdata),
        .control        (control),
        .txdata         (txdata),
        .start          (start),
        .start_rejected (start_rejected),
        .rd_rx          (rd_rx),
        .rdata          (rdata)
    );

    spi_clock_gen u_spi_clock_gen (
        .HCLK       (HCLK),
        .slave_cs   (slave_cs),
        .run        (run),
        .div_sel    (control.div_sel),
        .cpol       (control.cpol),
        .sclk       (sclk),
        .lead_edge  (lead_edge),
        .trail_edge (trail_edge)
    );

    spi_shift_engine u_spi_shift_engine (
        .HCLK       (HCLK),
        .slave_cs   (slave_cs),
        .start      (start),
        .txdata     (txdata),
        .cpha       (control.cpha),
        .miso       (miso),
        .lead_edge  (lead_edge),
        .trail_edge (trail_edge),
        .run        (run),
        .mosi       (mosi),
        .stat       (eng_stat),
        .rx_byte    (rx_byte)
    );

    spi_rx_status u_spi_rx_status (
        .HCLK     (HCLK),
        .slave_cs (slave_cs),
        .stat     (rx_stat),
        .rx_byte  (rx_byte),
        .start    (start),
        .rd_rx    (rd_rx),
        .rxdata   (rxdata),
        .status   (status)
    );

    a_one_slave: assert property (
        @(posedge HCLK) disable iff (slave_cs)
        $onehot0(~ss)
    ) else $error("more than one slave select low");

endmodule

// File: source/spi_reg_decode.sv
`timescale 1ns/1ps

module spi_reg_decode (
    input  logic                  HCLK,
    input  logic                  slave_cs,
    input  spi_pkg::host_req_t    req,
    input  logic                  busy,
    input  spi_pkg::spi_status_t  status,
    input  spi_pkg::spi_byte_t    rxdata,
    output spi_pkg::spi_control_t control,
    output spi_pkg::spi_byte_t    txdata,
    output logic                  start,
    output logic                  start_rejected,
    output logic                  rd_rx,
    output spi_pkg::spi_byte_t    rdata
);

    logic wr_en;                                 // Host write this cycle
    logic rd_en;                                 // Host read this cycle
    logic tx_wr;                                 // Write to transmit register
    logic engine_busy;                           // Busy or start already issued

    assign wr_en       = req.cs & req.wr;
    assign rd_en       = req.cs & req.rd;
    assign tx_wr       = wr_en & (req.addr == spi_pkg::ADDR_TXDATA);
    assign engine_busy = busy | start;           // Covers the cycle before busy rises

    // Control register
    always_ff @(posedge HCLK or posedge slave_cs) begin
        if (slave_cs) begin
            control <= '0;                       // CPOL 0 so sclk idles low
        end else if (wr_en && (req.addr == spi_pkg::ADDR_CONTROL)) begin
            control <= spi_pkg::spi_control_t'(req.wdata);
        end
    end

    // Transmit buffer keeps its value on a dropped write
    always_ff @(posedge HCLK) begin
        if (tx_wr && !engine_busy) begin
            txdata <= req.wdata;
        end
    end

    // One cycle strobes to the engine and result block
    always_ff @(posedge HCLK or posedge slave_cs) begin
        if (slave_cs) begin
            start          <= 1'b0;
            start_rejected <= 1'b0;
            rd_rx          <= 1'b0;
        end else begin
            start          <= tx_wr & ~engine_busy;   // Accepted transmit write
            start_rejected <= tx_wr & engine_busy;    // Overrun
            rd_rx          <= rd_en & (req.addr == spi_pkg::ADDR_RXDATA);
        end
    end

    // Read data is valid the cycle after the read
    always_ff @(posedge HCLK) begin
        if (rd_en) begin
            unique case (req.addr)
                spi_pkg::ADDR_CONTROL: rdata <= spi_pkg::spi_byte_t'(control);
                spi_pkg::ADDR_STATUS:  rdata <= spi_pkg::spi_byte_t'(status);
                spi_pkg::ADDR_TXDATA:  rdata <= txdata;
                spi_pkg::ADDR_RXDATA:  rdata <= rxdata;
            endcase
        end
    end

    // Start only reaches an idle engine and never pairs with a reject
    a_start_xor_reject: assert property (
        @(posedge HCLK) disable iff (slave_cs)
        start |-> (!start_rejected && !busy)
    ) else $error("start issued together with a reject or while the engine was busy");

endmodule

// File: source/spi_rx_status.sv
`timescale 1ns/1ps

module spi_rx_status (
    input  logic                  HCLK,
    input  logic                  slave_cs,
    input  spi_pkg::engine_stat_t stat,
    input  spi_pkg::spi_byte_t    rx_byte,
    input  logic                  start,
    input  logic                  rd_rx,
    output spi_pkg::spi_byte_t    rxdata,
    output spi_pkg::spi_status_t  status
);

    logic done_q;                                // Sticky until read or new word
    logic overrun_q;                             // Sticky until next accepted write

    // Receive buffer
    always_ff @(posedge HCLK) begin
        if (stat.word_done) begin
            rxdata <= rx_byte;
        end
    end

    always_ff @(posedge HCLK or posedge slave_cs) begin
        if (slave_cs) begin
            done_q    <= 1'b0;
            overrun_q <= 1'b0;
        end else if (start) begin
            done_q    <= 1'b0;                   // New word clears both flags
            overrun_q <= 1'b0;
        end else begin
            if (rd_rx) begin
                done_q <= 1'b0;
            end
            if (stat.word_done) begin
                done_q <= 1'b1;                  // Set wins over a read
            end
            if (stat.start_rejected) begin
                overrun_q <= 1'b1;
            end
        end
    end

    assign status = '{
        reserved: '0,
        busy:     stat.busy,
        overrun:  overrun_q,
        done:     done_q
    };

    // Done only shows once the engine has gone idle
    a_done_not_busy: assert property (
        @(posedge HCLK) disable iff (slave_cs)
        stat.busy |-> !done_q
    ) else $error("done set while a transfer is running");

endmodule

// File: sources.f
common/spi_pkg.sv
source/spi_reg_decode.sv
spi_engine/spi_clock_gen.sv
spi_engine/spi_shift_engine.sv
source/spi_rx_status.sv
source/spi_master_top.sv
bench/spi_clock_source.sv
bench/spi_checker.sv
bench/tb_spi_master.sv

// File: spi_engine/spi_clock_gen.sv
`timescale 1ns/1ps

module spi_clock_gen (
    input  logic              HCLK,
    input  logic              slave_cs,
    input  logic              run,
    input  spi_pkg::div_sel_t div_sel,
    input  logic              cpol,
    output logic              sclk,
    output logic              lead_edge,
    output logic              trail_edge
);

    logic [6:0] div_cnt;                         // Wraps at 128, a multiple of every half period
    logic [6:0] half_m1;                         // Half period minus one
    logic       tick;                            // sclk toggles on the next HCLK edge

    assign half_m1 = 7'((8'd1 << div_sel) - 8'd1);

    // Low bits all ones marks the end of a half period
    assign tick = run && ((div_cnt & half_m1) == half_m1);

    // Both pulses are high in the cycle whose closing edge moves sclk
    assign lead_edge  = tick && (sclk == cpol);  // Leaving idle level
    assign trail_edge = tick && (sclk != cpol);  // Back to idle level

    always_ff @(posedge HCLK or posedge slave_cs) begin
        if (slave_cs) begin
            div_cnt <= '0;
            sclk    <= 1'b0;                     // Control resets with CPOL 0
        end else if (!run) begin
            div_cnt <= '0;                       // First edge a full half period after run
            sclk    <= cpol;                     // Park at idle level
        end else begin
            div_cnt <= div_cnt + 7'd1;
            if (tick) begin
                sclk <= ~sclk;
            end
        end
    end

    // Between transfers sclk only moves to follow a new CPOL
    a_sclk_idle: assert property (
        @(posedge HCLK) disable iff (slave_cs)
        $past(!run) |-> ($stable(sclk) || ($past(cpol) != $past(cpol, 2)))
    ) else $error("sclk moved while the clock generator was stopped");

endmodule

// File: spi_engine/spi_shift_engine.sv
`timescale 1ns/1ps

module spi_shift_engine (
    input  logic                  HCLK,
    input  logic                  slave_cs,
    input  logic                  start,
    input  spi_pkg::spi_byte_t    txdata,
    input  logic                  cpha,
    input  logic                  miso,
    input  logic                  lead_edge,
    input  logic                  trail_edge,
    output logic                  run,
    output logic                  mosi,
    output spi_pkg::engine_stat_t stat,
    output spi_pkg::spi_byte_t    rx_byte
);

    typedef enum logic {
        IDLE,
        SHIFT
    } eng_state_t;

    eng_state_t         state;
    logic [4:0]         edge_cnt;                // sclk edges seen, 0 to 16
    logic               word_done;               // Registered end of word pulse
    spi_pkg::spi_byte_t tx_sr;                   // Outgoing bits, msb first
    spi_pkg::spi_byte_t rx_sr;                   // Incoming bits, shifted in at lsb
    logic               load;                    // Accept a new word
    logic               any_edge;
    logic               sample_edge;             // miso captured here
    logic               shift_edge;              // mosi moves here
    logic               last_edge;               // Sixteenth edge

    assign load        = (state == IDLE) && start;
    assign any_edge    = (state == SHIFT) && (lead_edge || trail_edge);
    assign sample_edge = (state == SHIFT) && (cpha ? trail_edge : lead_edge);
    assign shift_edge  = (state == SHIFT) && (cpha ? lead_edge : trail_edge);
    assign last_edge   = any_edge && (edge_cnt == 5'd15);

    assign run     = (state == SHIFT);
    assign rx_byte = rx_sr;

    // Rejects are found by the decoder and merged at the top
    assign stat = '{busy: run, word_done: word_done, start_rejected: 1'b0};

    // Busy FSM and edge counter
    always_ff @(posedge HCLK or posedge slave_cs) begin
        if (slave_cs) begin
            state     <= IDLE;
            edge_cnt  <= '0;
            word_done <= 1'b0;
        end else begin
            word_done <= last_edge;              // Same edge that drops busy
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= SHIFT;
                        edge_cnt <= '0;
                    end
                end
                SHIFT: begin
                    if (any_edge) begin
                        edge_cnt <= edge_cnt + 5'd1;
                    end
                    if (last_edge) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // mosi, msb first
    always_ff @(posedge HCLK or posedge slave_cs) begin
        if (slave_cs) begin
            mosi <= 1'b0;
        end else if (load) begin
            mosi <= cpha ? 1'b0 : txdata[7];     // CPHA 0 presents bit 7 before the first edge
        end else if (last_edge) begin
            mosi <= 1'b0;                        // Back to 0 between words
        end else if (shift_edge) begin
            mosi <= cpha ? tx_sr[7] : tx_sr[6];  // CPHA 0 already shows tx_sr[7]
        end
    end

    always_ff @(posedge HCLK) begin
        if (load) begin
            tx_sr <= txdata;
        end else if (shift_edge) begin
            tx_sr <= {tx_sr[6:0], 1'b0};
        end
    end

    always_ff @(posedge HCLK) begin
        if (sample_edge) begin
            rx_sr <= {rx_sr[6:0], miso};
        end
    end

    a_edge_cnt_max: assert property (
        @(posedge HCLK) disable iff (slave_cs)
        edge_cnt <= 5'd16
    ) else $error("edge count ran past 16");

endmodule
